//--- fp64Pkg.sv
// shared binary64 field positions, APB and result structs, and register map for the compare unit
package fp64Pkg;

	// ==============================
	// binary64 field positions
	// ==============================
	localparam int MSB  = 63;	// sign bit
	localparam int EMSB = 10;	// top bit of the 11-bit exponent field
	localparam int FMSB = 51;	// top bit of the 52-bit mantissa field

	// one operand split into fields and special-case flags
	typedef struct packed {
		logic [MSB:0]    raw;	// operand as written
		logic            sgn;
		logic [EMSB:0]   exp;
		logic [FMSB:0]   man;
		logic [FMSB+1:0] fract;	// mantissa with hidden bit recovered
		logic            xz;	// exponent is zero, denormal or zero
		logic            mz;	// mantissa is zero
		logic            vz;	// value is zero
		logic            inf;	// all ones exponent, zero mantissa
		logic            xinf;	// all ones exponent
		logic            qnan;	// quiet nan, top mantissa bit set
		logic            snan;	// signalling nan
		logic            nan;
	} fpParts_t;

	// IEEE style compare outcome, lt sits in the top bit
	typedef struct packed {
		logic lt;
		logic eq;
		logic gt;
		logic unord;	// at least one nan
		logic invalid;	// at least one signalling nan
	} cmpResult_t;

	// one-hot class, negInf lands in bit 0 and qNaN in bit 9
	typedef struct packed {
		logic qNaN;
		logic sNaN;
		logic posInf;
		logic posNorm;
		logic posSub;
		logic posZero;
		logic negZero;
		logic negSub;
		logic negNorm;
		logic negInf;
	} fpClass_t;

	// ==============================
	// APB bus
	// ==============================
	typedef struct packed {
		logic [7:0]  paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;	// tied high, no wait states
		logic        pslverr;
	} apbRsp_t;

	// register offsets
	localparam logic [7:0] ADDR_A_LO    = 8'h00;
	localparam logic [7:0] ADDR_A_HI    = 8'h04;
	localparam logic [7:0] ADDR_B_LO    = 8'h08;
	localparam logic [7:0] ADDR_B_HI    = 8'h0C;
	localparam logic [7:0] ADDR_CTRL    = 8'h10;	// bit 0 written as 1 starts
	localparam logic [7:0] ADDR_STATUS  = 8'h14;	// done in bit 0, result in 5:1
	localparam logic [7:0] ADDR_CLASS_A = 8'h18;
	localparam logic [7:0] ADDR_CLASS_B = 8'h1C;

	localparam int CMP_LATENCY = 2;	// cycles from start strobe to done

endpackage

//--- fpDecomp64Reg.sv
// registered split of one binary64 operand into sign, exponent, mantissa and special-case flags
`timescale 1ns/1ps

module fpDecomp64Reg import fp64Pkg::*; (
	input  logic         clk,
	input  logic         rstN,
	input  logic         ce,	// capture the operand
	input  logic         validIn,
	input  logic [MSB:0] i,
	output fpParts_t     parts,
	output logic         validOut
);

	fpParts_t split;	// combinational decomposition of i

	// ==============================
	// field split
	// ==============================
	always_comb begin
		split.raw = i;
		split.sgn = i[MSB];
		split.exp = i[MSB-1:FMSB+1];
		split.man = i[FMSB:0];
		split.xz = ~(|split.exp);	// denormal or zero
		split.mz = ~(|split.man);
		split.vz = split.xz & split.mz;
		split.xinf = &split.exp;
		split.inf = split.xinf & split.mz;

		// nan kind comes from the top mantissa bit
		split.qnan = split.xinf & split.man[FMSB];
		split.snan = split.xinf & ~split.man[FMSB] & ~split.mz;
		split.nan = split.xinf & ~split.mz;

		// hidden bit is one unless exponent is zero
		split.fract = {~split.xz, split.man};
	end

	// ==============================
	// output registers
	// ==============================
	always_ff @(posedge clk) begin
		if (ce) begin
			parts <= split;	// payload only, held between starts
		end
	end

	// valid runs one cycle behind the capture
	always_ff @(posedge clk) begin
		if (!rstN) begin
			validOut <= 1'b0;
		end else begin
			validOut <= validIn;
		end
	end

endmodule

//--- fpCmpClassify64.sv
// compare of two decomposed binary64 operands plus one-hot class of each, registered on valid
`timescale 1ns/1ps

module fpCmpClassify64 import fp64Pkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  logic       validIn,
	input  fpParts_t   partsA,
	input  fpParts_t   partsB,
	output cmpResult_t result,
	output fpClass_t   classA,
	output fpClass_t   classB,
	output logic       done
);

	cmpResult_t cmpNext;
	fpClass_t   classANext;
	fpClass_t   classBNext;
	logic       magAGt;	// |a| > |b| on exponent and mantissa
	logic       sameRaw;

	// one-hot class from the flags, nan checked first
	function automatic fpClass_t classify(input fpParts_t p);
		fpClass_t c;
		c = '0;
		if (p.snan) c.sNaN = 1'b1;
		else if (p.qnan) c.qNaN = 1'b1;
		else if (p.inf) begin
			c.negInf = p.sgn;
			c.posInf = ~p.sgn;
		end else if (p.vz) begin
			c.negZero = p.sgn;
			c.posZero = ~p.sgn;
		end else if (p.xz) begin	// exponent zero, mantissa nonzero
			c.negSub = p.sgn;
			c.posSub = ~p.sgn;
		end else begin
			c.negNorm = p.sgn;
			c.posNorm = ~p.sgn;
		end
		return c;
	endfunction

	// ==============================
	// compare
	// ==============================
	assign magAGt = partsA.raw[MSB-1:0] > partsB.raw[MSB-1:0];
	assign sameRaw = partsA.raw == partsB.raw;

	always_comb begin
		cmpNext = '0;
		if (partsA.nan | partsB.nan) begin
			cmpNext.unord = 1'b1;
			cmpNext.invalid = partsA.snan | partsB.snan;	// signalling nan raises invalid
		end else if (partsA.vz & partsB.vz) begin
			cmpNext.eq = 1'b1;	// +0 == -0
		end else if (sameRaw) begin
			cmpNext.eq = 1'b1;
		end else if (partsA.sgn != partsB.sgn) begin
			cmpNext.lt = partsA.sgn;	// negative side is smaller
			cmpNext.gt = partsB.sgn;
		end else begin
			// magnitude order, flipped when both are negative
			cmpNext.gt = magAGt ^ partsA.sgn;
			cmpNext.lt = ~(magAGt ^ partsA.sgn);
		end
	end

	assign classANext = classify(partsA);
	assign classBNext = classify(partsB);

	// ==============================
	// output registers
	// ==============================
	always_ff @(posedge clk) begin
		if (validIn) begin
			result <= cmpNext;
			classA <= classANext;
			classB <= classBNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) done <= 1'b0;
		else done <= validIn;	// one cycle pulse per operation
	end

endmodule

//--- fpCmpApbRegs.sv
// APB slave register file holding the operands, start control, status and result readback
`timescale 1ns/1ps

module fpCmpApbRegs import fp64Pkg::*; (
	input  logic         clk,
	input  logic         rstN,
	input  apbReq_t      apbReq,
	output apbRsp_t      apbRsp,
	output logic [63:0]  opA,
	output logic [63:0]  opB,
	output logic         start,	// one cycle strobe to the decomposers
	input  cmpResult_t   result,
	input  fpClass_t     classA,
	input  fpClass_t     classB,
	input  logic         done
);

	logic        access;	// access phase, completes this cycle
	logic        addrHit;	// mapped offset
	logic        roAddr;	// read-only offset
	logic        errAcc;
	logic        wrOk;
	logic [31:0] rdData;
	logic        doneBit;	// sticky status done
	cmpResult_t  resultReg;
	fpClass_t    classAReg;
	fpClass_t    classBReg;

	// ==============================
	// address decode
	// ==============================
	assign access = apbReq.psel & apbReq.penable;

	always_comb begin
		addrHit = 1'b1;
		roAddr = 1'b0;
		case (apbReq.paddr)
			ADDR_A_LO, ADDR_A_HI, ADDR_B_LO, ADDR_B_HI, ADDR_CTRL: roAddr = 1'b0;
			ADDR_STATUS, ADDR_CLASS_A, ADDR_CLASS_B: roAddr = 1'b1;
			default: addrHit = 1'b0;
		endcase
	end

	assign errAcc = access & (~addrHit | (apbReq.pwrite & roAddr));
	assign wrOk = access & apbReq.pwrite & ~errAcc;

	// read mux, ctrl reads back as zero
	always_comb begin
		rdData = '0;
		case (apbReq.paddr)
			ADDR_A_LO:    rdData = opA[31:0];
			ADDR_A_HI:    rdData = opA[63:32];
			ADDR_B_LO:    rdData = opB[31:0];
			ADDR_B_HI:    rdData = opB[63:32];
			ADDR_STATUS:  rdData = {26'd0, resultReg, doneBit};
			ADDR_CLASS_A: rdData = {22'd0, classAReg};
			ADDR_CLASS_B: rdData = {22'd0, classBReg};
			default:      rdData = '0;
		endcase
	end

	assign apbRsp = '{
		prdata:  (access & ~apbReq.pwrite) ? rdData : 32'd0,
		pready:  1'b1,
		pslverr: errAcc
	};

	// ==============================
	// registers
	// ==============================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			opA <= '0;
			opB <= '0;
			start <= 1'b0;
			doneBit <= 1'b0;
			resultReg <= '0;
			classAReg <= '0;
			classBReg <= '0;
		end else begin
			// strobe lands the cycle after the ctrl access phase
			start <= wrOk & (apbReq.paddr == ADDR_CTRL) & apbReq.pwdata[0];
			if (wrOk) begin
				case (apbReq.paddr)
					ADDR_A_LO: opA[31:0] <= apbReq.pwdata;
					ADDR_A_HI: opA[63:32] <= apbReq.pwdata;
					ADDR_B_LO: opB[31:0] <= apbReq.pwdata;
					ADDR_B_HI: opB[63:32] <= apbReq.pwdata;
					default: ;	// ctrl has no storage
				endcase
			end
			if (start) doneBit <= 1'b0;	// a new start wins over an older done
			else if (done) doneBit <= 1'b1;
			if (done) begin	// newest result replaces the last one
				resultReg <= result;
				classAReg <= classA;
				classBReg <= classB;
			end
		end
	end

endmodule

//--- fpCmpUnit.sv
// top of the binary64 compare and classify unit behind an APB slave port
`timescale 1ns/1ps

module fpCmpUnit import fp64Pkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  apbReq_t apbReq,
	output apbRsp_t apbRsp
);

	logic [63:0] opA;
	logic [63:0] opB;
	logic        start;
	logic        partsValid;	// start delayed through decomposer A
	fpParts_t    partsA;
	fpParts_t    partsB;
	cmpResult_t  result;
	fpClass_t    classA;
	fpClass_t    classB;
	logic        done;

	// ==============================
	// host side
	// ==============================
	fpCmpApbRegs apbRegs_i (
		.clk(clk), .rstN(rstN),
		.apbReq(apbReq), .apbRsp(apbRsp),
		.opA(opA), .opB(opB), .start(start),
		.result(result), .classA(classA), .classB(classB), .done(done)
	);

	// ==============================
	// datapath
	// ==============================
	fpDecomp64Reg decompA_i (
		.clk(clk), .rstN(rstN), .ce(start), .validIn(start),
		.i(opA), .parts(partsA), .validOut(partsValid)
	);

	fpDecomp64Reg decompB_i (	// valid taken from A only
		.clk(clk), .rstN(rstN), .ce(start), .validIn(start),
		.i(opB), .parts(partsB), .validOut()
	);

	fpCmpClassify64 cmpClassify_i (
		.clk(clk), .rstN(rstN), .validIn(partsValid),
		.partsA(partsA), .partsB(partsB),
		.result(result), .classA(classA), .classB(classB), .done(done)
	);

endmodule

//--- tbFpCmpUnit.sv
// testbench for the binary64 compare and classify unit driven over APB against a reference model
`timescale 1ns/1ps

module tbFpCmpUnit import fp64Pkg::*; ();

	// ==============================
	// run length and limits
	// ==============================
	localparam int OP_CYCLES = 27;	// 9 transfers of 3 cycles per operation
	localparam int NUM_OPS = 81 + 200 + 3;	// directed, random, back-to-back
	localparam int RUN_CYCLES = NUM_OPS * OP_CYCLES + 48;	// plus reset, readback, errors
	localparam int CYCLE_LIMIT = RUN_CYCLES * 3 / 2;

	logic    clk;
	logic    rstN;
	apbReq_t apbReq;
	apbRsp_t apbRsp;
	int      errCount = 0;
	int      testPass = 0;
	int      testFail = 0;
	int      cycles = 0;

	// ±0, ±inf, min subnormal, ±1.0, qNaN, sNaN
	logic [63:0] specials [9] = '{64'h0000000000000000, 64'h8000000000000000,
		64'h7FF0000000000000, 64'hFFF0000000000000, 64'h0000000000000001,
		64'h3FF0000000000000, 64'hBFF0000000000000, 64'h7FF8000000000000,
		64'h7FF0000000000001};

	fpCmpUnit fpCmpUnit_i (.clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	always @(posedge clk) begin	// watchdog
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// ==============================
	// reference model
	// ==============================
	function automatic fpClass_t classOf(input logic [63:0] v);
		fpClass_t c;
		c = '0;
		if (v[62:52] == 11'h7FF) begin
			if (v[51:0] == 0) c.posInf = 1'b1;	// sign applied below
			else if (v[51]) c.qNaN = 1'b1;
			else c.sNaN = 1'b1;
		end else if (v[62:52] == 0) begin
			if (v[51:0] == 0) c.posZero = 1'b1;
			else c.posSub = 1'b1;
		end else c.posNorm = 1'b1;
		if (v[63] && !c.qNaN && !c.sNaN)	// mirror onto the negative side
			c = '{negInf: c.posInf, negNorm: c.posNorm, negSub: c.posSub,
				negZero: c.posZero, default: 1'b0};
		return c;
	endfunction

	function automatic void refCompare(input logic [63:0] a, input logic [63:0] b,
			output cmpResult_t r, output fpClass_t ca, output fpClass_t cb);
		longint keyA;
		longint keyB;
		ca = classOf(a);
		cb = classOf(b);
		r = '0;
		keyA = a[63] ? -longint'({1'b0, a[62:0]}) : longint'({1'b0, a[62:0]});	// signed order
		keyB = b[63] ? -longint'({1'b0, b[62:0]}) : longint'({1'b0, b[62:0]});
		if (ca.qNaN | ca.sNaN | cb.qNaN | cb.sNaN) begin
			r.unord = 1'b1;
			r.invalid = ca.sNaN | cb.sNaN;
		end else begin
			r.lt = keyA < keyB;	// both zeros land on key 0
			r.eq = keyA == keyB;
			r.gt = keyA > keyB;
		end
	endfunction

	// ==============================
	// compare tasks
	// ==============================
	task automatic checkResult(input string name, input cmpResult_t exp, input cmpResult_t act);
		if (exp !== act) begin
			errCount++;
			$display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	task automatic checkClass(input string name, input fpClass_t exp, input fpClass_t act);
		if (exp !== act) begin
			errCount++;
			$display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	task automatic checkData(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errCount++;
			$display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errCount++;
			$display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	// ==============================
	// APB driver
	// ==============================
	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		apbReq <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: data};
		@(posedge clk);
		apbReq.penable <= 1'b1;
		@(negedge clk);
		err = apbRsp.pslverr;
		checkFlag("pready", 1'b1, apbRsp.pready);	// no wait states allowed
		@(posedge clk);	// write lands on this edge
		apbReq <= '0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		apbReq <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: 32'd0};
		@(posedge clk);
		apbReq.penable <= 1'b1;
		@(negedge clk);	// read data is combinational in access
		data = apbRsp.prdata;
		err = apbRsp.pslverr;
		checkFlag("pready", 1'b1, apbRsp.pready);
		@(posedge clk);
		apbReq <= '0;
	endtask

	task automatic loadOperands(input logic [63:0] a, input logic [63:0] b);
		logic err;
		apbWrite(ADDR_A_LO, a[31:0], err);
		apbWrite(ADDR_A_HI, a[63:32], err);
		apbWrite(ADDR_B_LO, b[31:0], err);
		apbWrite(ADDR_B_HI, b[63:32], err);
	endtask

	// poll until done, then compare against the model
	task automatic checkOutcome(input logic [63:0] a, input logic [63:0] b);
		cmpResult_t expR;
		fpClass_t   expA;
		fpClass_t   expB;
		logic [31:0] rd;
		logic       err;
		refCompare(a, b, expR, expA, expB);
		do apbRead(ADDR_STATUS, rd, err); while (!rd[0]);
		checkResult("result", expR, cmpResult_t'(rd[5:1]));
		apbRead(ADDR_CLASS_A, rd, err);
		checkClass("classA", expA, fpClass_t'(rd[9:0]));
		apbRead(ADDR_CLASS_B, rd, err);
		checkClass("classB", expB, fpClass_t'(rd[9:0]));
	endtask

	task automatic runOp(input logic [63:0] a, input logic [63:0] b);
		logic err;
		loadOperands(a, b);
		apbWrite(ADDR_CTRL, 32'd1, err);
		checkOutcome(a, b);
	endtask

	task automatic finishTest(input string name, input int errBefore);
		if (errCount == errBefore) testPass++;
		else testFail++;
		$display("test %-22s %s", name, (errCount == errBefore) ? "ok" : "FAILED");
	endtask

	// sign, exponent mix and mantissa picked to reach every class
	function automatic logic [63:0] randOperand();
		logic [10:0] e;
		logic [63:0] r;
		case ($urandom % 6)
			0: e = 11'h000;	// zero or subnormal
			1: e = 11'h7FF;	// inf or nan
			default: e = $urandom;
		endcase
		r = {$urandom, $urandom};
		if ($urandom % 4 == 0) r[51:0] = '0;
		return {r[63], e, r[51:0]};
	endfunction

	// ==============================
	// test sequence
	// ==============================
	initial begin
		logic [63:0] a;
		logic [63:0] b;
		logic [31:0] rd;
		logic [31:0] expStatus;
		logic [31:0] wr [4];
		logic        err;
		int          e0;
		cmpResult_t  expR;
		fpClass_t    expA;
		fpClass_t    expB;
		a = $urandom(84234);	// seed once
		apbReq <= '0;
		rstN <= 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		e0 = errCount;	// reset state
		apbRead(ADDR_STATUS, rd, err);
		checkData("status", 32'd0, rd);
		checkFlag("pslverr", 1'b0, err);
		apbRead(ADDR_CLASS_A, rd, err);
		checkData("classA", 32'd0, rd);
		apbRead(ADDR_CLASS_B, rd, err);
		checkData("classB", 32'd0, rd);
		finishTest("reset state", e0);

		e0 = errCount;
		foreach (specials[x]) foreach (specials[y]) runOp(specials[x], specials[y]);
		finishTest("directed specials", e0);

		e0 = errCount;
		repeat (200) begin
			a = randOperand();
			b = ($urandom % 8 == 0) ? a : randOperand();	// some equal pairs
			runOp(a, b);
		end
		finishTest("random operands", e0);

		e0 = errCount;
		foreach (wr[k]) wr[k] = $urandom;
		loadOperands({wr[1], wr[0]}, {wr[3], wr[2]});
		foreach (wr[k]) begin
			apbRead(8'(k * 4), rd, err);	// A_LO, A_HI, B_LO, B_HI
			checkData("operand half", wr[k], rd);
		end
		finishTest("operand readback", e0);

		// status still holds the last random pair with done set
		e0 = errCount;
		refCompare(a, b, expR, expA, expB);
		expStatus = {26'd0, expR, 1'b1};
		apbRead(ADDR_STATUS, rd, err);
		checkData("status", expStatus, rd);
		apbRead(8'h24, rd, err);
		checkFlag("pslverr unmapped", 1'b1, err);
		apbWrite(ADDR_STATUS, 32'hFFFF_FFFF, err);
		checkFlag("pslverr status write", 1'b1, err);
		apbRead(ADDR_STATUS, rd, err);
		checkData("status", expStatus, rd);
		checkFlag("pslverr", 1'b0, err);
		finishTest("error response", e0);

		e0 = errCount;
		runOp(specials[5], specials[6]);	// one settled run before two starts without polling
		loadOperands(specials[2], specials[8]);
		apbWrite(ADDR_CTRL, 32'd1, err);
		loadOperands(specials[6], specials[1]);
		apbWrite(ADDR_CTRL, 32'd1, err);
		checkOutcome(specials[6], specials[1]);
		finishTest("back-to-back starts", e0);

		$display("tests passed %0d, failed %0d, errors %0d", testPass, testFail, errCount);
		if (testFail == 0 && errCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- sources.f
fp64Pkg.sv
fpDecomp64Reg.sv
fpCmpClassify64.sv
fpCmpApbRegs.sv
fpCmpUnit.sv
tbFpCmpUnit.sv

//--- Bender.yml
package:
  name: fp_cmp_unit

sources:
  - fp64Pkg.sv
  - fpDecomp64Reg.sv
  - fpCmpClassify64.sv
  - fpCmpApbRegs.sv
  - fpCmpUnit.sv
  - target: test
    files:
      - tbFpCmpUnit.sv
